//--- rtl/rv_isa_pkg.sv
// RV32I instruction-set definitions
// Word type, major opcodes, load/store width codes and branch conditions

package rv_isa_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_op_imm = 7'b0010011,
    op_op     = 7'b0110011
  } opcode_e;

  // Load/store width, funct3 field
  localparam logic [2:0] funct3_byte  = 3'b000;
  localparam logic [2:0] funct3_half  = 3'b001;
  localparam logic [2:0] funct3_word  = 3'b010;
  localparam logic [2:0] funct3_ubyte = 3'b100;
  localparam logic [2:0] funct3_uhalf = 3'b101;

  // Branch conditions, funct3 field
  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

endpackage

//--- rtl/rv_ctl_pkg.sv
// Core control definitions
// ALU functions, writeback source and next-PC source

package rv_ctl_pkg;

  // Compare functions return 1 or 0, branches use them directly
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_seq,
    alu_sne,
    alu_sge,
    alu_sgeu
  } alu_function_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc_plus4,
    wb_imm
  } wb_select_e;

  typedef enum logic [1:0] {
    npc_plus4,
    npc_branch,
    npc_jal,
    npc_jalr
  } next_pc_select_e;

endpackage

//--- rtl/ctl_if.sv
// Decoded control bundle between control path and datapath

`timescale 1ns/100ps

interface ctl_if;

  rv_ctl_pkg::alu_function_e   alu_function;
  // 0 selects rs1, 1 selects pc
  logic                        alu_operand_a_select;
  // 0 selects rs2, 1 selects the immediate
  logic                        alu_operand_b_select;
  logic                        regfile_write_enable;
  rv_ctl_pkg::wb_select_e      reg_writeback_select;
  rv_ctl_pkg::next_pc_select_e next_pc_select;

  modport ctl (
    output alu_function, alu_operand_a_select, alu_operand_b_select,
    output regfile_write_enable, reg_writeback_select, next_pc_select
  );

  modport dp (
    input alu_function, alu_operand_a_select, alu_operand_b_select,
    input regfile_write_enable, reg_writeback_select, next_pc_select
  );

endinterface

//--- rtl/alu.sv
// Integer ALU
// Add, subtract, shifts, logic operations and compares

`timescale 1ns/100ps

module alu (
  input  rv_ctl_pkg::alu_function_e alu_function,
  input  rv_isa_pkg::word_t         operand_a,
  input  rv_isa_pkg::word_t         operand_b,
  output rv_isa_pkg::word_t         result
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      rv_ctl_pkg::alu_add:  result = operand_a + operand_b;
      rv_ctl_pkg::alu_sub:  result = operand_a - operand_b;
      rv_ctl_pkg::alu_sll:  result = operand_a << shamt;
      rv_ctl_pkg::alu_srl:  result = operand_a >> shamt;
      rv_ctl_pkg::alu_sra:  result = $signed(operand_a) >>> shamt;
      rv_ctl_pkg::alu_xor:  result = operand_a ^ operand_b;
      rv_ctl_pkg::alu_or:   result = operand_a | operand_b;
      rv_ctl_pkg::alu_and:  result = operand_a & operand_b;
      // Compares give a single bit, zero extended
      rv_ctl_pkg::alu_slt:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      rv_ctl_pkg::alu_sltu: result = {31'b0, operand_a < operand_b};
      rv_ctl_pkg::alu_seq:  result = {31'b0, operand_a == operand_b};
      rv_ctl_pkg::alu_sne:  result = {31'b0, operand_a != operand_b};
      rv_ctl_pkg::alu_sge:  result = {31'b0, $signed(operand_a) >= $signed(operand_b)};
      rv_ctl_pkg::alu_sgeu: result = {31'b0, operand_a >= operand_b};
      default:              result = '0;
    endcase
  end

endmodule

//--- rtl/regfile.sv
// 32 x 32 register file
// Two combinational read ports, one write port, x0 reads as zero

`timescale 1ns/100ps

module regfile (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              write_enable,
  input  logic [4:0]        rd_address,
  input  logic [4:0]        rs1_address,
  input  logic [4:0]        rs2_address,
  input  rv_isa_pkg::word_t rd_data,
  output rv_isa_pkg::word_t rs1_data,
  output rv_isa_pkg::word_t rs2_data
);

  rv_isa_pkg::word_t regs [32];

  // x0 is cleared on reset and never written
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd_address != 5'd0) begin
      regs[rd_address] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_address];
  assign rs2_data = regs[rs2_address];

endmodule

//--- rtl/singlecycle_datapath.sv
// Single-cycle datapath
// PC register, instruction fields, immediates, ALU operand and writeback muxes

`timescale 1ns/100ps

module singlecycle_datapath #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clock,
  input  logic              rst_n,
  input  rv_isa_pkg::word_t inst,
  input  rv_isa_pkg::word_t data_mem_read_data,
  ctl_if.dp                 ctl,
  output logic [6:0]        inst_opcode,
  output logic [2:0]        inst_funct3,
  output logic [6:0]        inst_funct7,
  output rv_isa_pkg::word_t rs2_data,
  output rv_isa_pkg::word_t alu_result,
  output rv_isa_pkg::word_t pc
);

  logic [4:0]        inst_rd;
  logic [4:0]        inst_rs1;
  logic [4:0]        inst_rs2;
  rv_isa_pkg::word_t immediate;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t operand_a;
  rv_isa_pkg::word_t operand_b;
  rv_isa_pkg::word_t writeback_data;
  rv_isa_pkg::word_t pc_plus4;
  rv_isa_pkg::word_t pc_target;
  rv_isa_pkg::word_t next_pc;

  assign inst_opcode = inst[6:0];
  assign inst_rd     = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign inst_rs1    = inst[19:15];
  assign inst_rs2    = inst[24:20];
  assign inst_funct7 = inst[31:25];

  // Immediate format follows the major opcode, I-type otherwise
  always_comb begin
    case (rv_isa_pkg::opcode_e'(inst_opcode))
      rv_isa_pkg::op_store:
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      rv_isa_pkg::op_branch:
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc:
        immediate = {inst[31:12], 12'b0};
      rv_isa_pkg::op_jal:
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  regfile regs (
    .clock        (clock),
    .rst_n        (rst_n),
    .write_enable (ctl.regfile_write_enable),
    .rd_address   (inst_rd),
    .rs1_address  (inst_rs1),
    .rs2_address  (inst_rs2),
    .rd_data      (writeback_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign operand_a = ctl.alu_operand_a_select ? pc : rs1_data;
  assign operand_b = ctl.alu_operand_b_select ? immediate : rs2_data;

  alu alu_unit (
    .alu_function (ctl.alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .result       (alu_result)
  );

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + immediate;

  always_comb begin
    case (ctl.reg_writeback_select)
      rv_ctl_pkg::wb_mem:      writeback_data = data_mem_read_data;
      rv_ctl_pkg::wb_pc_plus4: writeback_data = pc_plus4;
      rv_ctl_pkg::wb_imm:      writeback_data = immediate;
      default:                 writeback_data = alu_result;
    endcase
  end

  // Branch resolution has already been folded in by the control path
  always_comb begin
    case (ctl.next_pc_select)
      rv_ctl_pkg::npc_branch,
      rv_ctl_pkg::npc_jal:  next_pc = pc_target;
      rv_ctl_pkg::npc_jalr: next_pc = {alu_result[31:1], 1'b0};
      default:              next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- rtl/singlecycle_ctlpath.sv
// Single-cycle control path
// Opcode decode, ALU function mapping and branch resolution

`timescale 1ns/100ps

module singlecycle_ctlpath (
  input  logic [6:0]        inst_opcode,
  input  logic [2:0]        inst_funct3,
  input  logic [6:0]        inst_funct7,
  input  rv_isa_pkg::word_t alu_result,
  ctl_if.ctl                ctl,
  output logic              data_mem_read_enable,
  output logic              data_mem_write_enable
);

  rv_isa_pkg::opcode_e         opcode;
  rv_ctl_pkg::alu_function_e   arith_function;
  rv_ctl_pkg::alu_function_e   branch_function;
  rv_ctl_pkg::next_pc_select_e decoded_next_pc;

  assign opcode = rv_isa_pkg::opcode_e'(inst_opcode);

  // OP and OP-IMM share funct3; bit 30 picks SUB only for OP
  always_comb begin
    case (inst_funct3)
      3'b000: begin
        if (opcode == rv_isa_pkg::op_op && inst_funct7[5]) begin
          arith_function = rv_ctl_pkg::alu_sub;
        end else begin
          arith_function = rv_ctl_pkg::alu_add;
        end
      end
      3'b001:  arith_function = rv_ctl_pkg::alu_sll;
      3'b010:  arith_function = rv_ctl_pkg::alu_slt;
      3'b011:  arith_function = rv_ctl_pkg::alu_sltu;
      3'b100:  arith_function = rv_ctl_pkg::alu_xor;
      3'b101:  arith_function = inst_funct7[5] ? rv_ctl_pkg::alu_sra : rv_ctl_pkg::alu_srl;
      3'b110:  arith_function = rv_ctl_pkg::alu_or;
      default: arith_function = rv_ctl_pkg::alu_and;
    endcase
  end

  // Nonzero compare result means taken
  always_comb begin
    case (inst_funct3)
      rv_isa_pkg::funct3_beq:  branch_function = rv_ctl_pkg::alu_seq;
      rv_isa_pkg::funct3_bne:  branch_function = rv_ctl_pkg::alu_sne;
      rv_isa_pkg::funct3_blt:  branch_function = rv_ctl_pkg::alu_slt;
      rv_isa_pkg::funct3_bge:  branch_function = rv_ctl_pkg::alu_sge;
      rv_isa_pkg::funct3_bltu: branch_function = rv_ctl_pkg::alu_sltu;
      default:                 branch_function = rv_ctl_pkg::alu_sgeu;
    endcase
  end

  always_comb begin
    // Safe defaults, also used for undefined opcodes
    ctl.alu_function         = rv_ctl_pkg::alu_add;
    ctl.alu_operand_a_select = 1'b0;
    ctl.alu_operand_b_select = 1'b1;
    ctl.regfile_write_enable = 1'b0;
    ctl.reg_writeback_select = rv_ctl_pkg::wb_alu;
    decoded_next_pc          = rv_ctl_pkg::npc_plus4;
    data_mem_read_enable     = 1'b0;
    data_mem_write_enable    = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::wb_imm;
      end
      rv_isa_pkg::op_auipc: begin
        ctl.alu_operand_a_select = 1'b1;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::wb_pc_plus4;
        decoded_next_pc          = rv_ctl_pkg::npc_jal;
      end
      rv_isa_pkg::op_jalr: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::wb_pc_plus4;
        decoded_next_pc          = rv_ctl_pkg::npc_jalr;
      end
      rv_isa_pkg::op_branch: begin
        ctl.alu_function         = branch_function;
        ctl.alu_operand_b_select = 1'b0;
        decoded_next_pc          = rv_ctl_pkg::npc_branch;
      end
      rv_isa_pkg::op_load: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::wb_mem;
        data_mem_read_enable     = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        data_mem_write_enable = 1'b1;
      end
      rv_isa_pkg::op_op_imm: begin
        ctl.alu_function         = arith_function;
        ctl.regfile_write_enable = 1'b1;
      end
      rv_isa_pkg::op_op: begin
        ctl.alu_function         = arith_function;
        ctl.alu_operand_b_select = 1'b0;
        ctl.regfile_write_enable = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Not-taken branch falls through to pc+4
  assign ctl.next_pc_select =
      (decoded_next_pc == rv_ctl_pkg::npc_branch && alu_result == '0) ?
      rv_ctl_pkg::npc_plus4 : decoded_next_pc;

endmodule

//--- rtl/data_memory_interface.sv
// Data bus adapter
// Store lane replication and byte enables, load alignment and extension

`timescale 1ns/100ps

module data_memory_interface (
  input  rv_isa_pkg::word_t address,
  input  logic [2:0]        data_format,
  input  rv_isa_pkg::word_t write_data,
  input  rv_isa_pkg::word_t bus_read_data,
  output rv_isa_pkg::word_t bus_write_data,
  output logic [3:0]        bus_byte_enable,
  output rv_isa_pkg::word_t read_data
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // Stores drive every lane, byte enables pick the ones that commit
  always_comb begin
    case (data_format)
      rv_isa_pkg::funct3_byte, rv_isa_pkg::funct3_ubyte: begin
        bus_write_data  = {4{write_data[7:0]}};
        bus_byte_enable = 4'b0001 << address[1:0];
      end
      rv_isa_pkg::funct3_half, rv_isa_pkg::funct3_uhalf: begin
        bus_write_data  = {2{write_data[15:0]}};
        bus_byte_enable = address[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        bus_write_data  = write_data;
        bus_byte_enable = 4'b1111;
      end
    endcase
  end

  // Lane selection ignores misalignment within the word
  assign byte_lane = bus_read_data[address[1:0]*8 +: 8];
  assign half_lane = address[1] ? bus_read_data[31:16] : bus_read_data[15:0];

  always_comb begin
    case (data_format)
      rv_isa_pkg::funct3_byte:  read_data = {{24{byte_lane[7]}}, byte_lane};
      rv_isa_pkg::funct3_ubyte: read_data = {24'b0, byte_lane};
      rv_isa_pkg::funct3_half:  read_data = {{16{half_lane[15]}}, half_lane};
      rv_isa_pkg::funct3_uhalf: read_data = {16'b0, half_lane};
      default:                  read_data = bus_read_data;
    endcase
  end

endmodule

//--- rtl/riscv_core.sv
// Single-cycle RV32I core top level
// Datapath, control path and data bus adapter on plain bus ports

`timescale 1ns/100ps

module riscv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clock,
  input  logic              rst_n,
  input  rv_isa_pkg::word_t inst,
  input  rv_isa_pkg::word_t bus_read_data,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t alu_result,
  output rv_isa_pkg::word_t bus_write_data,
  output logic              bus_write_enable,
  output logic              bus_read_enable,
  output logic [3:0]        bus_byte_enable
);

  logic [6:0]        inst_opcode;
  logic [2:0]        inst_funct3;
  logic [6:0]        inst_funct7;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t dmem_read_data;

  ctl_if ctl_bus ();

  singlecycle_datapath #(
    .reset_pc (reset_pc)
  ) datapath (
    .clock              (clock),
    .rst_n              (rst_n),
    .inst               (inst),
    .data_mem_read_data (dmem_read_data),
    .ctl                (ctl_bus.dp),
    .inst_opcode        (inst_opcode),
    .inst_funct3        (inst_funct3),
    .inst_funct7        (inst_funct7),
    .rs2_data           (rs2_data),
    .alu_result         (alu_result),
    .pc                 (pc)
  );

  singlecycle_ctlpath ctlpath (
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result            (alu_result),
    .ctl                   (ctl_bus.ctl),
    .data_mem_read_enable  (bus_read_enable),
    .data_mem_write_enable (bus_write_enable)
  );

  // ALU result is the effective address for loads and stores
  data_memory_interface dmem (
    .address         (alu_result),
    .data_format     (inst_funct3),
    .write_data      (rs2_data),
    .bus_read_data   (bus_read_data),
    .bus_write_data  (bus_write_data),
    .bus_byte_enable (bus_byte_enable),
    .read_data       (dmem_read_data)
  );

endmodule

//--- tests/tb_riscv_core.sv
// Testbench for riscv_core
// Program builder, instruction and data memory models, ISA reference model,
// compare tasks and cycle timeout

`timescale 1ns/100ps

module tb_riscv_core;

  logic              clock = 1'b0;
  logic              rst_n;
  rv_isa_pkg::word_t inst;
  rv_isa_pkg::word_t bus_read_data;
  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t alu_result;
  rv_isa_pkg::word_t bus_write_data;
  logic              bus_write_enable;
  logic              bus_read_enable;
  logic [3:0]        bus_byte_enable;

  rv_isa_pkg::word_t imem [512];
  rv_isa_pkg::word_t dmem [64];
  rv_isa_pkg::word_t ref_mem [64];
  rv_isa_pkg::word_t ref_regs [32];
  rv_isa_pkg::word_t ref_pc, cur_pc, halt_pc, exp_wdata, exp_addr, lane_mask;
  logic              exp_we, exp_re;
  logic [3:0]        exp_be;
  integer            seed;
  int                prog_len, cycle_limit, cycle_count;

  riscv_core #(.reset_pc(32'h0)) i_dut (
    .clock (clock), .rst_n (rst_n), .inst (inst), .bus_read_data (bus_read_data),
    .pc (pc), .alu_result (alu_result), .bus_write_data (bus_write_data),
    .bus_write_enable (bus_write_enable), .bus_read_enable (bus_read_enable),
    .bus_byte_enable (bus_byte_enable)
  );

  always #10 clock = ~clock;

  // Data memory commits enabled lanes at the rising edge
  always @(posedge clock) begin
    if (bus_write_enable) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_byte_enable[i]) dmem[alu_result[7:2]][8*i +: 8] <= bus_write_data[8*i +: 8];
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: program end not reached within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bits(input string name, input logic [3:0] expected,
                            input logic [3:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "bits mismatch");
    end
  endtask

  // Instruction encoders
  function automatic rv_isa_pkg::word_t op_word(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_op};
  endfunction

  function automatic rv_isa_pkg::word_t imm_word(input rv_isa_pkg::opcode_e opc,
      input logic [11:0] imm, input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::word_t store_word(input logic [2:0] f3, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic rv_isa_pkg::word_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_isa_pkg::word_t upper_word(input rv_isa_pkg::opcode_e opc,
      input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic rv_isa_pkg::word_t jump_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  task automatic emit(input rv_isa_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input rv_isa_pkg::word_t v);
    rv_isa_pkg::word_t up;
    up = (v + 32'h800) >> 12;
    emit(upper_word(rv_isa_pkg::op_lui, rd, up[19:0]));
    emit(imm_word(rv_isa_pkg::op_op_imm, v[11:0], rd, 3'b000, rd));
  endtask

  // SW rs, 0(x10) puts the register value on the bus
  task automatic store_result(input logic [4:0] rs);
    emit(store_word(rv_isa_pkg::funct3_word, rs, 5'd10, 12'd0));
  endtask

  task automatic build_program();
    logic [4:0]        pair_a [5];
    logic [4:0]        pair_b [5];
    logic [2:0]        f3;
    logic [11:0]       imm;
    int                width;
    rv_isa_pkg::word_t first_value;
    pair_a = '{5'd1, 5'd3, 5'd1, 5'd3, 5'd1};
    pair_b = '{5'd2, 5'd1, 5'd3, 5'd5, 5'd4};
    prog_len = 0;
    first_value = $random(seed);
    load_const(5'd1, first_value);
    load_const(5'd2, $random(seed));
    load_const(5'd3, $random(seed) | 32'h8000_0000);
    // x4 equals x1 for the equal-operand pair
    load_const(5'd4, first_value);
    load_const(5'd5, $random(seed) | 32'h0000_001c);
    load_const(5'd10, 32'h40);
    // Register-register ops with SUB and SRA last
    for (int p = 0; p < 5; p++) begin
      for (int f = 0; f < 10; f++) begin
        f3 = (f < 8) ? 3'(f) : ((f == 8) ? 3'd0 : 3'd5);
        emit(op_word((f < 8) ? 7'h00 : 7'h20, pair_b[p], pair_a[p], f3, 5'd20));
        store_result(5'd20);
      end
    end
    // Immediate ops with SRAI last
    for (int r = 1; r <= 3; r += 2) begin
      for (int f = 0; f < 9; f++) begin
        f3 = (f < 8) ? 3'(f) : 3'd5;
        imm = 12'($random(seed));
        if (f3 == 3'd1 || f3 == 3'd5) imm = {(f == 8) ? 7'h20 : 7'h00, imm[4:0]};
        emit(imm_word(rv_isa_pkg::op_op_imm, imm, 5'(r), f3, 5'd20));
        store_result(5'd20);
      end
    end
    emit(store_word(rv_isa_pkg::funct3_word, 5'd3, 5'd10, 12'd16));
    emit(store_word(rv_isa_pkg::funct3_half, 5'd1, 5'd10, 12'd20));
    emit(store_word(rv_isa_pkg::funct3_half, 5'd2, 5'd10, 12'd22));
    for (int b = 0; b < 4; b++) begin
      emit(store_word(rv_isa_pkg::funct3_byte, 5'(b + 2), 5'd10, 12'(24 + b)));
    end
    // Every legal load width at every offset and a store of each result
    for (int off = 16; off < 28; off++) begin
      for (int f = 0; f < 6; f++) begin
        width = 1 << f[1:0];
        if (f != 3 && off % width == 0) begin
          emit(imm_word(rv_isa_pkg::op_load, 12'(off), 5'd10, 3'(f), 5'd21));
          store_result(5'd21);
        end
      end
    end
    // Taken branches skip the counter increment
    for (int f = 0; f < 8; f++) begin
      for (int p = 0; p < 5; p++) begin
        if (f != 2 && f != 3) begin
          emit(branch_word(3'(f), pair_a[p], pair_b[p], 13'd8));
          emit(imm_word(rv_isa_pkg::op_op_imm, 12'd1, 5'd22, 3'b000, 5'd22));
        end
      end
    end
    store_result(5'd22);
    emit(jump_word(5'd23, 21'd8));
    emit(imm_word(rv_isa_pkg::op_op_imm, 12'd1, 5'd22, 3'b000, 5'd22));
    store_result(5'd23);
    emit(upper_word(rv_isa_pkg::op_auipc, 5'd24, 20'($random(seed))));
    store_result(5'd24);
    emit(upper_word(rv_isa_pkg::op_lui, 5'd25, 20'($random(seed))));
    store_result(5'd25);
    // JALR to an odd target three words ahead
    emit(upper_word(rv_isa_pkg::op_auipc, 5'd26, 20'd0));
    emit(imm_word(rv_isa_pkg::op_jalr, 12'd13, 5'd26, 3'b000, 5'd27));
    emit(imm_word(rv_isa_pkg::op_op_imm, 12'd1, 5'd22, 3'b000, 5'd22));
    store_result(5'd27);
    store_result(5'd22);
    emit(imm_word(rv_isa_pkg::op_op_imm, 12'h7ff, 5'd1, 3'b000, 5'd0));
    emit(upper_word(rv_isa_pkg::op_lui, 5'd0, 20'($random(seed))));
    store_result(5'd0);
    halt_pc = 32'(prog_len * 4);
    emit(jump_word(5'd0, 21'd0));
  endtask

  function automatic rv_isa_pkg::word_t arith_result(input logic [2:0] f3, input logic sub,
      input logic sra, input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        // Arithmetic shift kept apart so the sign is not lost
        if (sra) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Steps the shadow state by one instruction and returns the next pc
  function automatic rv_isa_pkg::word_t ref_step(input rv_isa_pkg::word_t ir,
      input rv_isa_pkg::word_t cur, output logic we, output logic re, output logic [3:0] be,
      output rv_isa_pkg::word_t wdata, output rv_isa_pkg::word_t addr);
    rv_isa_pkg::word_t a, b, rd_val, npc, lane, imm_i, imm_s, imm_b, imm_j;
    logic              wr, take;
    a = ref_regs[ir[19:15]];
    b = ref_regs[ir[24:20]];
    imm_i = {{20{ir[31]}}, ir[31:20]};
    imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    we = 1'b0;
    re = 1'b0;
    be = 4'b0;
    wdata = '0;
    addr = '0;
    wr = 1'b1;
    take = 1'b0;
    rd_val = '0;
    npc = cur + 4;
    case (ir[6:0])
      rv_isa_pkg::op_lui:    rd_val = {ir[31:12], 12'b0};
      rv_isa_pkg::op_auipc:  rd_val = cur + {ir[31:12], 12'b0};
      rv_isa_pkg::op_op_imm: rd_val = arith_result(ir[14:12], 1'b0, ir[30], a, imm_i);
      rv_isa_pkg::op_op:     rd_val = arith_result(ir[14:12], ir[30], ir[30], a, b);
      rv_isa_pkg::op_jal: begin
        rd_val = cur + 4;
        npc = cur + imm_j;
      end
      rv_isa_pkg::op_jalr: begin
        rd_val = cur + 4;
        npc = (a + imm_i) & ~32'd1;
      end
      rv_isa_pkg::op_branch: begin
        wr = 1'b0;
        case (ir[14:12])
          rv_isa_pkg::funct3_beq:  take = (a == b);
          rv_isa_pkg::funct3_bne:  take = (a != b);
          rv_isa_pkg::funct3_blt:  take = ($signed(a) < $signed(b));
          rv_isa_pkg::funct3_bge:  take = ($signed(a) >= $signed(b));
          rv_isa_pkg::funct3_bltu: take = (a < b);
          default:                 take = (a >= b);
        endcase
        if (take) npc = cur + imm_b;
      end
      rv_isa_pkg::op_load: begin
        re = 1'b1;
        addr = a + imm_i;
        lane = ref_mem[addr[7:2]] >> {addr[1:0], 3'b0};
        case (ir[14:12])
          rv_isa_pkg::funct3_byte:  rd_val = {{24{lane[7]}}, lane[7:0]};
          rv_isa_pkg::funct3_ubyte: rd_val = {24'b0, lane[7:0]};
          rv_isa_pkg::funct3_half:  rd_val = {{16{lane[15]}}, lane[15:0]};
          rv_isa_pkg::funct3_uhalf: rd_val = {16'b0, lane[15:0]};
          default:                  rd_val = lane;
        endcase
      end
      rv_isa_pkg::op_store: begin
        wr = 1'b0;
        we = 1'b1;
        addr = a + imm_s;
        case (ir[14:12])
          rv_isa_pkg::funct3_byte: begin
            be = 4'b0001 << addr[1:0];
            wdata = {24'b0, b[7:0]} << {addr[1:0], 3'b0};
          end
          rv_isa_pkg::funct3_half: begin
            be = 4'b0011 << {addr[1], 1'b0};
            wdata = {16'b0, b[15:0]} << {addr[1], 4'b0};
          end
          default: begin
            be = 4'b1111;
            wdata = b;
          end
        endcase
        for (int i = 0; i < 4; i++) begin
          if (be[i]) ref_mem[addr[7:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && ir[11:7] != 5'd0) ref_regs[ir[11:7]] = rd_val;
    return npc;
  endfunction

  initial begin
    seed = 70380;
    rst_n = 1'b0;
    inst = '0;
    bus_read_data = '0;
    cycle_count = 0;
    for (int i = 0; i < 512; i++) imem[i] = '0;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = {~16'(i), 16'(i) ^ 16'h5a00};
      ref_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    build_program();
    cycle_limit = 10 + 2 * prog_len;
    ref_pc = 32'h0;
    // Reset phase with the all-zero word on inst
    repeat (9) begin
      @(negedge clock);
      #5;
      check_word("pc", 32'h0, pc);
      check_bits("bus_read_enable", 4'b0, {3'b0, bus_read_enable});
      check_bits("bus_write_enable", 4'b0, {3'b0, bus_write_enable});
    end
    @(negedge clock);
    rst_n = 1'b1;
    while (ref_pc != halt_pc) begin
      inst = imem[pc[10:2]];
      cur_pc = ref_pc;
      ref_pc = ref_step(inst, cur_pc, exp_we, exp_re, exp_be, exp_wdata, exp_addr);
      bus_read_data = dmem[exp_addr[7:2]];
      #5;
      check_word("pc", cur_pc, pc);
      check_bits("bus_write_enable", {3'b0, exp_we}, {3'b0, bus_write_enable});
      check_bits("bus_read_enable", {3'b0, exp_re}, {3'b0, bus_read_enable});
      if (exp_we || exp_re) check_word("alu_result", exp_addr, alu_result);
      if (exp_we) begin
        lane_mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
        check_bits("bus_byte_enable", exp_be, bus_byte_enable);
        check_word("bus_write_data", exp_wdata & lane_mask, bus_write_data & lane_mask);
      end
      @(negedge clock);
    end
    check_word("pc", halt_pc, pc);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- tb.f
rtl/rv_isa_pkg.sv
rtl/rv_ctl_pkg.sv
rtl/ctl_if.sv
rtl/alu.sv
rtl/regfile.sv
rtl/singlecycle_datapath.sv
rtl/singlecycle_ctlpath.sv
rtl/data_memory_interface.sv
rtl/riscv_core.sv
tests/tb_riscv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the riscv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_riscv_core -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
